/* vlog.f */
source/hdc_pkg.sv
source/encode_core.sv
source/result_arbiter.sv
source/bundle_buffer.sv
source/apb_regs.sv
source/hdc_bundler_top.sv
tests/hdc_bundler_assertions.sv
tests/tb_hdc_bundler.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_hdc_bundler \
    -Mdir "$BUILD_DIR" -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_hdc_bundler" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "testbench reported failure"
    exit 1
fi

echo "run complete, no failure reported"
exit 0

/* tests/tb_hdc_bundler.sv */
module tb_hdc_bundler;
    timeunit 1ns;
    timeprecision 1ps;
    import hdc_pkg::*;

    localparam int POLL_LIMIT = 40;

    // one table row: what to load, which cores to start, and what to do around it
    typedef struct packed {
        logic [NUM_CORES-1:0][HV_DIM-1:0] sample;
        logic [NUM_CORES-1:0][HV_DIM-1:0] key;
        logic [PERM_W-1:0]                perm;
        logic [NUM_CORES-1:0]             mask;
        logic                             clr;
        logic                             snap;
    } row_t;

    logic              clk;
    logic              arst_n;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;

    row_t              rows[$];
    string             labels[$];
    int                model_cnt[HV_DIM];
    int                model_count;
    logic [HV_DIM-1:0] exp_result;
    int                checks;
    int                test_checks;
    int                test_errors;
    int                errors;
    logic              aborted;

    hdc_bundler_top i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            test_errors++;
            errors++;
        end
    endtask

    // setup cycle then access cycle, response sampled mid access
    task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] wdata, input logic exp_err,
                              output logic [APB_DW-1:0] rdata);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        compare_word($sformatf("pslverr@%02h", addr), 32'(pslverr), 32'(exp_err));
        compare_word("pready", 32'(pready), 32'd1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        logic [APB_DW-1:0] ignored;
        apb_access(1'b1, addr, data, 1'b0, ignored);
    endtask

    task automatic read_reg(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        apb_access(1'b0, addr, '0, 1'b0, data);
    endtask

    // bit i of the bound vector lands at bit (i + perm) mod HV_DIM
    function automatic logic [HV_DIM-1:0] expect_bound(input logic [HV_DIM-1:0] s,
                                                       input logic [HV_DIM-1:0] k,
                                                       input logic [PERM_W-1:0] p);
        logic [HV_DIM-1:0] x;
        logic [HV_DIM-1:0] r;
        x = s ^ k;
        for (int i = 0; i < HV_DIM; i++) begin
            r[(i + int'(p)) % HV_DIM] = x[i];
        end
        return r;
    endfunction

    task automatic model_vote(input logic [HV_DIM-1:0] v);
        for (int i = 0; i < HV_DIM; i++) begin
            if (v[i] && model_cnt[i] < 127) begin
                model_cnt[i]++;
            end else if (!v[i] && model_cnt[i] > -127) begin
                model_cnt[i]--;
            end
        end
        if (model_count < 255) begin
            model_count++;
        end
    endtask

    function automatic logic [HV_DIM-1:0] model_sign();
        logic [HV_DIM-1:0] s;
        for (int i = 0; i < HV_DIM; i++) begin
            s[i] = (model_cnt[i] > 0);
        end
        return s;
    endfunction

    task automatic wait_idle(output logic ok);
        logic [APB_DW-1:0] st;
        ok = 1'b0;
        for (int n = 0; n < POLL_LIMIT && !ok; n++) begin
            read_reg(ADDR_STATUS, st);
            ok = (st[NUM_CORES-1:0] == '0);
        end
        if (!ok) begin
            for (int c = 0; c < NUM_CORES; c++) begin
                if (st[c]) begin
                    $display("TIMEOUT: core %0d stayed busy after %0d status polls",
                             c, POLL_LIMIT);
                end
            end
            errors++;
        end
    endtask

    task automatic apply_row(input row_t row);
        logic ok;
        if (row.clr) begin
            write_reg(ADDR_CTRL, APB_DW'(1) << CTRL_CLEAR_BIT);
            foreach (model_cnt[i]) begin
                model_cnt[i] = 0;
            end
            model_count = 0;
        end
        write_reg(ADDR_PERM, APB_DW'(row.perm));
        for (int c = 0; c < NUM_CORES; c++) begin
            if (row.mask[c]) begin
                write_reg(ADDR_SAMPLE_BASE + APB_AW'(4 * c), row.sample[c]);
                write_reg(ADDR_KEY_BASE + APB_AW'(4 * c), row.key[c]);
            end
        end
        write_reg(ADDR_CTRL, APB_DW'(row.mask));
        wait_idle(ok);
        if (!ok) begin
            aborted = 1'b1;
        end
        // multi core rows start near zero, so vote order does not matter
        for (int c = 0; c < NUM_CORES; c++) begin
            if (row.mask[c]) begin
                model_vote(expect_bound(row.sample[c], row.key[c], row.perm));
            end
        end
        if (row.snap) begin
            write_reg(ADDR_CTRL, APB_DW'(1) << CTRL_SNAP_BIT);
            exp_result = model_sign();
        end
    endtask

    task automatic check_state();
        logic [APB_DW-1:0] rd;
        read_reg(ADDR_SIGN, rd);
        compare_word("SIGN", rd, model_sign());
        read_reg(ADDR_STATUS, rd);
        compare_word("STATUS", rd, {16'h0, 8'(model_count), 8'h0});
        read_reg(ADDR_RESULT, rd);
        compare_word("RESULT", rd, exp_result);
    endtask

    task automatic end_test(input string name);
        $display("test %-12s finished: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic add_row(input string label, input row_t row);
        rows.push_back(row);
        labels.push_back(label);
    endtask

    task automatic build_table();
        row_t              row;
        logic [HV_DIM-1:0] vecs [4];
        logic [PERM_W-1:0] perms [4];
        vecs  = '{32'h8000_0001, 32'h1234_5678, 32'hDEAD_BEEF, 32'h0F0F_00FF};
        perms = '{5'd0, 5'd31, 5'd7, 5'd13};
        // one core alone per row, perm sweep including both ends
        for (int c = 0; c < NUM_CORES; c++) begin
            row = '0;
            row.sample[c] = vecs[c];
            row.key[c]    = ~vecs[(c + 1) % 4];
            row.perm      = perms[c];
            row.mask      = NUM_CORES'(1) << c;
            row.clr       = 1'b1;
            add_row("single_core", row);
        end
        for (int r = 0; r < 2; r++) begin
            row = '0;
            for (int c = 0; c < NUM_CORES; c++) begin
                row.sample[c] = vecs[c];
                row.key[c]    = vecs[(c + 2 + r) % 4];
            end
            row.perm = r ? 5'd29 : 5'd3;
            row.mask = '1;
            row.clr  = 1'b1;
            add_row("all_cores", row);
        end
        // push past the rails, then pull back the other way
        row = '0;
        row.sample[2] = 32'hF0F0_A5C3;
        row.mask      = 4'b0100;
        for (int n = 0; n < 130; n++) begin
            row.clr = (n == 0);
            add_row("saturation", row);
        end
        row.sample[2] = ~row.sample[2];
        row.clr       = 1'b0;
        for (int n = 0; n < 128; n++) begin
            add_row("saturation", row);
        end
        row = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            row.sample[c] = vecs[c];
        end
        row.perm = 5'd9;
        row.mask = '1;
        row.clr  = 1'b1;
        row.snap = 1'b1;
        add_row("snapshot", row);
        row.sample = {NUM_CORES{32'hFFFF_0000}};
        row.mask   = 4'b0111;
        row.clr    = 1'b0;
        row.snap   = 1'b0;
        add_row("snapshot", row);
        row = '0;
        row.clr = 1'b1;
        add_row("clear", row);
        for (int r = 0; r < 10; r++) begin
            row = '0;
            for (int c = 0; c < NUM_CORES; c++) begin
                row.sample[c] = $urandom;
                row.key[c]    = $urandom;
            end
            row.perm = PERM_W'($urandom);
            row.mask = NUM_CORES'($urandom);
            row.clr  = (r == 0);
            add_row("random", row);
        end
    endtask

    task automatic run_error_test();
        logic [APB_DW-1:0] rd;
        write_reg(ADDR_PERM, 32'd17);
        write_reg(ADDR_SAMPLE_BASE, 32'hA5A5_5A5A);
        write_reg(ADDR_KEY_BASE + 8'h0C, 32'h0123_4567);
        // 0x3F would start every core, clear and snapshot if accepted
        apb_access(1'b1, ADDR_STATUS, 32'h0000_003F, 1'b1, rd);
        apb_access(1'b1, ADDR_RESULT, 32'h0000_003F, 1'b1, rd);
        apb_access(1'b1, 8'h80, 32'h0000_003F, 1'b1, rd);
        apb_access(1'b0, 8'h80, '0, 1'b1, rd);
        apb_access(1'b1, 8'h14, 32'h0000_003F, 1'b1, rd);
        apb_access(1'b1, 8'h22, 32'h0000_003F, 1'b1, rd);
        apb_access(1'b0, 8'h30, '0, 1'b1, rd);
        read_reg(ADDR_PERM, rd);
        compare_word("PERM", rd, 32'd17);
        read_reg(ADDR_SAMPLE_BASE, rd);
        compare_word("SAMPLE0", rd, 32'hA5A5_5A5A);
        read_reg(ADDR_KEY_BASE + 8'h0C, rd);
        compare_word("KEY3", rd, 32'h0123_4567);
        check_state();
    endtask

    initial begin
        void'($urandom(18));
        arst_n      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        aborted     = 1'b0;
        exp_result  = '0;
        model_count = 0;
        build_table();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        compare_word("prdata", prdata, '0);
        compare_word("pslverr", 32'(pslverr), '0);
        check_state();
        end_test("reset");
        for (int r = 0; r < rows.size() && !aborted; r++) begin
            apply_row(rows[r]);
            check_state();
            if (r == rows.size() - 1 || labels[r + 1] != labels[r]) begin
                end_test(labels[r]);
            end
        end
        if (!aborted) begin
            run_error_test();
            end_test("apb_errors");
        end
        $display("summary: %0d checks, %0d errors%s", checks, errors,
                 aborted ? ", run stopped early on a timeout" : "");
        if (errors == 0 && !aborted) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* tests/hdc_bundler_assertions.sv */
module hdc_bundler_assertions (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          psel,
    input logic                          penable,
    input logic                          pslverr,
    input logic [hdc_pkg::NUM_CORES-1:0] req,
    input logic [hdc_pkg::NUM_CORES-1:0] grant,
    input logic                          bus_valid
);
    timeunit 1ns;
    timeprecision 1ps;
    import hdc_pkg::*;

    // a pending result stays requested until its grant
    for (genvar g = 0; g < NUM_CORES; g++) begin : g_hold
        a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
            req[g] && !grant[g] |=> req[g])
            else $error("core %0d dropped req without a grant", g);
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant))
        else $error("more than one grant in the same cycle");

    // error response only while the access phase is on the bus
    a_err_access: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> psel && penable)
        else $error("pslverr raised outside the access phase");

    // bus carries a vector exactly when some core has one pending
    a_valid_req: assert property (@(posedge clk) disable iff (!arst_n)
        bus_valid == |req)
        else $error("bus_valid does not match the pending requests");

endmodule

bind hdc_bundler_top hdc_bundler_assertions i_assertions (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pslverr   (pslverr),
    .req       (core_req),
    .grant     (core_grant),
    .bus_valid (bus_valid)
);

/* source/hdc_bundler_top.sv */
module hdc_bundler_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [hdc_pkg::APB_AW-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [hdc_pkg::APB_DW-1:0] pwdata,
    output logic [hdc_pkg::APB_DW-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr
);
    import hdc_pkg::*;

    logic [NUM_CORES-1:0]             core_start;
    logic [NUM_CORES-1:0][HV_DIM-1:0] core_sample;
    logic [NUM_CORES-1:0][HV_DIM-1:0] core_key;
    logic [PERM_W-1:0]                perm;
    logic [NUM_CORES-1:0]             core_req;
    logic [NUM_CORES-1:0]             core_grant;
    logic [NUM_CORES-1:0][HV_DIM-1:0] core_hv;
    logic                             bus_valid;
    logic [HV_DIM-1:0]                bus_hv;
    logic                             clear;
    logic                             snapshot;
    logic [HV_DIM-1:0]                sign_vec;
    logic [HV_DIM-1:0]                result_vec;
    logic [BCNT_W-1:0]                bundle_count;

    // a core is busy while its request is pending
    apb_regs i_regs (
        .clk          (clk),
        .arst_n       (arst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .start        (core_start),
        .sample       (core_sample),
        .key          (core_key),
        .perm         (perm),
        .clear        (clear),
        .snapshot     (snapshot),
        .busy         (core_req),
        .sign_vec     (sign_vec),
        .result_vec   (result_vec),
        .bundle_count (bundle_count)
    );

    for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
        encode_core i_core (
            .clk    (clk),
            .arst_n (arst_n),
            .start  (core_start[g]),
            .sample (core_sample[g]),
            .key    (core_key[g]),
            .perm   (perm),
            .grant  (core_grant[g]),
            .req    (core_req[g]),
            .hv     (core_hv[g])
        );
    end

    result_arbiter i_arb (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (core_req),
        .hv_in     (core_hv),
        .grant     (core_grant),
        .bus_valid (bus_valid),
        .bus_hv    (bus_hv)
    );

    bundle_buffer i_buf (
        .clk          (clk),
        .arst_n       (arst_n),
        .bus_valid    (bus_valid),
        .bus_hv       (bus_hv),
        .clear        (clear),
        .snapshot     (snapshot),
        .sign_vec     (sign_vec),
        .result_vec   (result_vec),
        .bundle_count (bundle_count)
    );

endmodule

/* source/apb_regs.sv */
module apb_regs (
    input  logic                                               clk,
    input  logic                                               arst_n,
    input  logic [hdc_pkg::APB_AW-1:0]                         paddr,
    input  logic                                               psel,
    input  logic                                               penable,
    input  logic                                               pwrite,
    input  logic [hdc_pkg::APB_DW-1:0]                         pwdata,
    output logic [hdc_pkg::APB_DW-1:0]                         prdata,
    output logic                                               pready,
    output logic                                               pslverr,
    output logic [hdc_pkg::NUM_CORES-1:0]                      start,
    output logic [hdc_pkg::NUM_CORES-1:0][hdc_pkg::HV_DIM-1:0] sample,
    output logic [hdc_pkg::NUM_CORES-1:0][hdc_pkg::HV_DIM-1:0] key,
    output logic [hdc_pkg::PERM_W-1:0]                         perm,
    output logic                                               clear,
    output logic                                               snapshot,
    input  logic [hdc_pkg::NUM_CORES-1:0]                      busy,
    input  logic [hdc_pkg::HV_DIM-1:0]                         sign_vec,
    input  logic [hdc_pkg::HV_DIM-1:0]                         result_vec,
    input  logic [hdc_pkg::BCNT_W-1:0]                         bundle_count
);
    import hdc_pkg::*;

    logic              access;
    logic              aligned;
    logic              hit_sample;
    logic              hit_key;
    logic              hit_ro;
    logic              mapped;
    logic              wr_en;
    logic [CORE_W-1:0] slot;

    // zero wait states
    assign pready = 1'b1;
    assign access = psel && penable;

    assign aligned = (paddr[1:0] == 2'b00);

    // sample and key banks sit on 16 byte boundaries, word index picks the core
    assign slot = paddr[CORE_W+1:2];
    assign hit_sample = aligned &&
        (paddr[APB_AW-1:CORE_W+2] == ADDR_SAMPLE_BASE[APB_AW-1:CORE_W+2]);
    assign hit_key = aligned &&
        (paddr[APB_AW-1:CORE_W+2] == ADDR_KEY_BASE[APB_AW-1:CORE_W+2]);

    // read-only registers
    assign hit_ro = (paddr == ADDR_STATUS) || (paddr == ADDR_RESULT) ||
                    (paddr == ADDR_SIGN);

    assign mapped = hit_ro || hit_sample || hit_key ||
                    (paddr == ADDR_CTRL) || (paddr == ADDR_PERM);

    assign pslverr = access && (!mapped || (pwrite && hit_ro));
    assign wr_en   = access && pwrite && !pslverr;

    // configuration registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample <= '0;
            key    <= '0;
            perm   <= '0;
        end else if (wr_en) begin
            if (hit_sample) begin
                sample[slot] <= pwdata;
            end else if (hit_key) begin
                key[slot] <= pwdata;
            end else if (paddr == ADDR_PERM) begin
                perm <= pwdata[PERM_W-1:0];
            end
        end
    end

    // command pulses last one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start    <= '0;
            clear    <= 1'b0;
            snapshot <= 1'b0;
        end else begin
            start    <= '0;
            clear    <= 1'b0;
            snapshot <= 1'b0;
            if (wr_en && paddr == ADDR_CTRL) begin
                start    <= pwdata[NUM_CORES-1:0];
                clear    <= pwdata[CTRL_CLEAR_BIT];
                snapshot <= pwdata[CTRL_SNAP_BIT];
            end
        end
    end

    // read mux, zero outside a read access
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hit_sample) begin
                prdata = sample[slot];
            end else if (hit_key) begin
                prdata = key[slot];
            end else begin
                case (paddr)
                    ADDR_STATUS: begin
                        prdata[NUM_CORES-1:0]               = busy;
                        prdata[STATUS_CNT_LSB +: BCNT_W]   = bundle_count;
                    end
                    ADDR_RESULT: begin
                        prdata = result_vec;
                    end
                    ADDR_SIGN: begin
                        prdata = sign_vec;
                    end
                    ADDR_PERM: begin
                        prdata[PERM_W-1:0] = perm;
                    end
                    // ctrl is write only and reads as zero
                    default: begin
                        prdata = '0;
                    end
                endcase
            end
        end
    end

endmodule

/* source/bundle_buffer.sv */
module bundle_buffer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       bus_valid,
    input  logic [hdc_pkg::HV_DIM-1:0] bus_hv,
    input  logic                       clear,
    input  logic                       snapshot,
    output logic [hdc_pkg::HV_DIM-1:0] sign_vec,
    output logic [hdc_pkg::HV_DIM-1:0] result_vec,
    output logic [hdc_pkg::BCNT_W-1:0] bundle_count
);
    import hdc_pkg::*;

    // one vote counter per dimension
    logic signed [CNT_W-1:0] cnt [HV_DIM];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < HV_DIM; i++) begin
                cnt[i] <= '0;
            end
        end else if (clear) begin
            // clear beats a vote in the same cycle
            for (int i = 0; i < HV_DIM; i++) begin
                cnt[i] <= '0;
            end
        end else if (bus_valid) begin
            for (int i = 0; i < HV_DIM; i++) begin
                if (bus_hv[i] && cnt[i] != CNT_MAX) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end else if (!bus_hv[i] && cnt[i] != CNT_MIN) begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
        end
    end

    // strictly positive counter votes 1, a tie votes 0
    always_comb begin
        for (int i = 0; i < HV_DIM; i++) begin
            sign_vec[i] = (cnt[i] > 0);
        end
    end

    // vectors bundled since the last clear
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bundle_count <= '0;
        end else if (clear) begin
            bundle_count <= '0;
        end else if (bus_valid && bundle_count != '1) begin
            bundle_count <= bundle_count + 1'b1;
        end
    end

    // snapshot freezes the sign vector seen before this edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_vec <= '0;
        end else if (snapshot) begin
            result_vec <= sign_vec;
        end
    end

endmodule

/* source/result_arbiter.sv */
module result_arbiter (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic [hdc_pkg::NUM_CORES-1:0]                 req,
    input  logic [hdc_pkg::NUM_CORES-1:0][hdc_pkg::HV_DIM-1:0] hv_in,
    output logic [hdc_pkg::NUM_CORES-1:0]                 grant,
    output logic                                          bus_valid,
    output logic [hdc_pkg::HV_DIM-1:0]                    bus_hv
);
    import hdc_pkg::*;

    // first core to look at in the next search
    logic [CORE_W-1:0] ptr;
    logic [CORE_W-1:0] winner;
    logic              found;

    // search starts at ptr and wraps around
    always_comb begin
        logic [CORE_W-1:0] idx;
        found  = 1'b0;
        winner = ptr;
        for (int k = 0; k < NUM_CORES; k++) begin
            idx = ptr + CORE_W'(k);
            if (!found && req[idx]) begin
                found  = 1'b1;
                winner = idx;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) begin
            grant[winner] = 1'b1;
        end
    end

    assign bus_valid = |grant;
    assign bus_hv    = found ? hv_in[winner] : '0;

    // NUM_CORES is a power of two, so the pointer wraps on its own
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= winner + 1'b1;
        end
    end

endmodule

/* source/encode_core.sv */
module encode_core (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    input  logic [hdc_pkg::HV_DIM-1:0] sample,
    input  logic [hdc_pkg::HV_DIM-1:0] key,
    input  logic [hdc_pkg::PERM_W-1:0] perm,
    input  logic                       grant,
    output logic                       req,
    output logic [hdc_pkg::HV_DIM-1:0] hv
);
    import hdc_pkg::*;

    logic [HV_DIM-1:0] bound;
    logic [HV_DIM-1:0] permuted;
    logic              accept;

    // rotate left: shift the doubled word and keep the upper half
    function automatic logic [HV_DIM-1:0] rotl(
        input logic [HV_DIM-1:0] x,
        input logic [PERM_W-1:0] n
    );
        logic [2*HV_DIM-1:0] doubled;
        doubled = {x, x} << n;
        return doubled[2*HV_DIM-1:HV_DIM];
    endfunction

    // binding is a plain xor
    assign bound    = sample ^ key;
    assign permuted = rotl(bound, perm);

    // a start while a result is still pending is dropped
    assign accept = start && !req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req <= 1'b0;
        end else if (accept) begin
            req <= 1'b1;
        end else if (grant) begin
            req <= 1'b0;
        end
    end

    // result held stable until the arbiter takes it
    always_ff @(posedge clk) begin
        if (accept) begin
            hv <= permuted;
        end
    end

endmodule

/* source/hdc_pkg.sv */
package hdc_pkg;

    // hypervector and core geometry
    localparam int HV_DIM    = 32;
    localparam int NUM_CORES = 4;
    localparam int CORE_W    = $clog2(NUM_CORES);
    localparam int PERM_W    = 5;

    // vote counters saturate symmetrically at +/-127
    localparam int CNT_W = 8;
    localparam logic signed [CNT_W-1:0] CNT_MAX = 8'sd127;
    localparam logic signed [CNT_W-1:0] CNT_MIN = -8'sd127;

    // bundled vector count, saturates at all ones
    localparam int BCNT_W = 8;

    // apb bus widths, one hypervector per data word
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // register map
    localparam logic [APB_AW-1:0] ADDR_CTRL        = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_STATUS      = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_RESULT      = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_SIGN        = 8'h0C;
    localparam logic [APB_AW-1:0] ADDR_PERM        = 8'h10;
    localparam logic [APB_AW-1:0] ADDR_SAMPLE_BASE = 8'h20;
    localparam logic [APB_AW-1:0] ADDR_KEY_BASE    = 8'h40;

    // ctrl and status fields
    localparam int CTRL_CLEAR_BIT = 4;
    localparam int CTRL_SNAP_BIT  = 5;
    localparam int STATUS_CNT_LSB = 8;

endpackage
